// File: Bender.yml
package:
  name: special_move_gen

sources:
  - logic/chess_board_pkg.sv
  - logic/move_pkg.sv
  - logic/castling_check.sv
  - logic/en_passant_finder.sv
  - logic/move_serializer.sv
  - logic/move_fifo.sv
  - logic/special_move_gen.sv
  - target: simulation
    files:
      - bench/clock_gen.sv
      - bench/special_move_gen_tb.sv

// File: bench/clock_gen.sv
module clock_gen #(
	parameter int period = 100
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	always begin
		#(period / 2) clk = ~clk; // 50/50 duty cycle
	end

endmodule

// File: bench/special_move_gen_tb.sv
module special_move_gen_tb;
	import chess_board_pkg::*;
	import move_pkg::*;

	localparam int directed_tests = 9;
	localparam int random_tests = 30;
	localparam int test_cycles = 40;
	localparam int timeout_cycles = test_cycles * (directed_tests + random_tests);

	logic clk;
	logic reset;
	board_t board;
	logic castle_king_ok;
	logic castle_queen_ok;
	file_mask_t en_passant_files;
	logic rden;
	move_t move_out;
	logic fifo_empty;
	logic done;

	move_t exp_moves [CANDIDATE_COUNT];
	int exp_count;
	int pop_index;
	int error_count;
	int pass_count;
	int fail_count;
	int cycle_count;
	string test_name;
	logic [31:0] lcg_state;

	clock_gen #(.period(100)) i_clock_gen (.clk(clk));

	special_move_gen #(.fifo_depth(32)) i_dut (
		.clk(clk),
		.reset(reset),
		.board(board),
		.castle_king_ok(castle_king_ok),
		.castle_queen_ok(castle_queen_ok),
		.en_passant_files(en_passant_files),
		.rden(rden),
		.move_out(move_out),
		.fifo_empty(fifo_empty),
		.done(done)
	);

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic piece_t square_piece(board_t b, int f, int r);
		return b[f * 32 + r * 4 +: 4];
	endfunction

	function automatic board_t with_piece(board_t b, int f, int r, piece_t p);
		b[f * 32 + r * 4 +: 4] = p;
		return b;
	endfunction

	function automatic logic vacant(piece_t p);
		return p[2:0] == 3'd0; // color bit does not matter
	endfunction

	function automatic move_t move_word(move_flags_t fl, int ff, int fr, int tf, int tr);
		return {fl, 3'(ff), 3'(fr), 3'(tf), 3'(tr)};
	endfunction

	// fills exp_moves in slot order and returns how many there are
	function automatic int ref_special_moves(board_t b, logic kok, logic qok, file_mask_t epf);
		int n;
		int src;
		n = 0;
		if (kok && square_piece(b, 4, 0) == {WHITE, KING} && vacant(square_piece(b, 5, 0))
			&& vacant(square_piece(b, 6, 0)) && square_piece(b, 7, 0) == {WHITE, ROOK}) begin
			exp_moves[n] = move_word(CASTLE_FLAGS, 4, 0, 6, 0); // e1 to g1
			n++;
		end
		if (qok && square_piece(b, 4, 0) == {WHITE, KING} && vacant(square_piece(b, 1, 0))
			&& vacant(square_piece(b, 2, 0)) && vacant(square_piece(b, 3, 0))
			&& square_piece(b, 0, 0) == {WHITE, ROOK}) begin
			exp_moves[n] = move_word(CASTLE_FLAGS, 4, 0, 2, 0); // e1 to c1
			n++;
		end
		for (int f = 0; f < 8; f++) begin
			for (int s = 0; s < 2; s++) begin
				src = f - 1 + 2 * s; // left neighbour first
				if (epf[f] && src >= 0 && src < 8) begin
					if (square_piece(b, src, 4) == {WHITE, PAWN}) begin
						exp_moves[n] = move_word(EN_PASSANT_FLAGS, src, 4, f, 5);
						n++;
					end
				end
			end
		end
		return n;
	endfunction

	// home pieces usually present, pawns on rank 5 often
	function automatic board_t random_board();
		board_t b;
		logic [31:0] rnd;
		piece_t p;
		b = '0;
		for (int f = 0; f < 8; f++) begin
			rnd = lcg_next();
			if (f == 4) begin
				p = (rnd[31:30] != 2'd0) ? {WHITE, KING} : 4'h0;
			end else if (f == 0 || f == 7) begin
				p = (rnd[31:30] != 2'd0) ? {WHITE, ROOK} : 4'h0;
			end else begin
				p = (rnd[31:30] == 2'd0) ? {rnd[29], 3'(2 + rnd[28:27])} : 4'h0;
			end
			b = with_piece(b, f, 0, p);
			case (rnd[26:25])
				2'd0, 2'd1: b = with_piece(b, f, 4, {WHITE, PAWN});
				2'd2: b = with_piece(b, f, 4, {BLACK, PAWN});
				default: b = with_piece(b, f, 4, 4'h0);
			endcase
			if (rnd[24:22] == 3'd0) begin
				b = with_piece(b, f, 2 + rnd[21], {rnd[19], 3'(1 + rnd[18:17])});
			end
		end
		return b;
	endfunction

	task automatic check_move(input string name, input move_t expected, input move_t actual);
		if (expected !== actual) begin
			$display("FAILED %s: expected move %h, actual %h", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		if (expected != actual) begin
			$display("FAILED %s: expected %0d moves, actual %0d", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_latency(input string name, input int expected, input int actual);
		if (expected != actual) begin
			$display("FAILED %s: expected done after %0d cycles, actual %0d", name, expected,
				actual);
			error_count++;
		end
	endtask

	// a head shown with rden high at the falling edge is popped at the next rising edge
	always @(negedge clk) begin
		if (rden && !fifo_empty) begin
			if (pop_index < exp_count) begin
				check_move(test_name, exp_moves[pop_index], move_out);
			end else begin
				$display("%s: FIFO holds more moves than expected", test_name);
				error_count++;
			end
			pop_index++;
		end
	end

	task automatic run_test(input string name, input board_t b, input logic kok,
		input logic qok, input file_mask_t epf);
		int errors_before;
		int edges;
		logic seen_done;
		errors_before = error_count;
		test_name = name;
		exp_count = ref_special_moves(b, kok, qok, epf);
		pop_index = 0;
		@(posedge clk);
		reset <= 1'b1;
		rden <= 1'b0;
		board <= b;
		castle_king_ok <= kok;
		castle_queen_ok <= qok;
		en_passant_files <= epf;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		edges = 0;
		seen_done = 1'b0;
		while (!seen_done && edges < test_cycles) begin
			@(posedge clk);
			edges++;
			@(negedge clk);
			seen_done = done;
		end
		if (!seen_done) begin
			$display("%s: done never rose", name);
			error_count++;
		end else begin
			check_latency(name, exp_count + 2, edges);
			if (exp_count > 0 && fifo_empty) begin
				$display("%s: FIFO empty at done although moves were expected", name);
				error_count++;
			end
			@(posedge clk);
			rden <= 1'b1;
			@(negedge clk);
			while (!fifo_empty) begin
				@(negedge clk);
			end
			@(posedge clk);
			rden <= 1'b0;
			check_count(name, exp_count, pop_index);
		end
		if (error_count == errors_before) begin
			$display("%s: ok, %0d moves", name, exp_count);
			pass_count++;
		end else begin
			$display("%s: %0d errors", name, error_count - errors_before);
			fail_count++;
		end
	endtask

	initial begin
		cycle_count = 0;
		while (cycle_count < timeout_cycles) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: run did not finish within %0d cycles", timeout_cycles);
		$display("Testbench failed");
		$finish;
	end

	initial begin
		board_t home;
		board_t b;
		logic [31:0] rnd;
		lcg_state = 32'hf69f_e9ca;
		error_count = 0;
		pass_count = 0;
		fail_count = 0;
		exp_count = 0;
		pop_index = 0;
		test_name = "init";
		reset <= 1'b1;
		rden <= 1'b0;
		board <= '0;
		castle_king_ok <= 1'b0;
		castle_queen_ok <= 1'b0;
		en_passant_files <= '0;

		home = with_piece('0, 4, 0, {WHITE, KING});
		home = with_piece(home, 0, 0, {WHITE, ROOK});
		home = with_piece(home, 7, 0, {WHITE, ROOK});

		run_test("empty_board", '0, 1'b0, 1'b0, 8'h00);
		run_test("castle_both", home, 1'b1, 1'b1, 8'h00);
		run_test("castle_f1_blocked", with_piece(home, 5, 0, {WHITE, KNIGHT}), 1'b1, 1'b1,
			8'h00);
		run_test("castle_no_a1_rook", with_piece(home, 0, 0, 4'h0), 1'b1, 1'b1, 8'h00);
		run_test("castle_king_flag_off", home, 1'b0, 1'b1, 8'h00);

		b = with_piece('0, 2, 4, {WHITE, PAWN}); // c5 and e5 beside file d
		b = with_piece(b, 4, 4, {WHITE, PAWN});
		run_test("ep_file_d", b, 1'b0, 1'b0, 8'b0000_1000);

		b = with_piece('0, 1, 4, {WHITE, PAWN});
		b = with_piece(b, 6, 4, {WHITE, PAWN});
		run_test("ep_files_a_h", b, 1'b0, 1'b0, 8'b1000_0001);

		run_test("ep_black_pawn", with_piece('0, 2, 4, {BLACK, PAWN}), 1'b0, 1'b0,
			8'b0000_1000);

		b = with_piece(home, 1, 4, {WHITE, PAWN});
		b = with_piece(b, 3, 4, {WHITE, PAWN});
		b = with_piece(b, 5, 4, {WHITE, PAWN});
		run_test("combined", b, 1'b1, 1'b1, 8'b0101_0101);

		for (int i = 0; i < random_tests; i++) begin
			b = random_board();
			rnd = lcg_next();
			run_test($sformatf("random_%0d", i), b, rnd[31], rnd[30], rnd[29:22]);
		end

		$display("%0d tests, %0d passed, %0d failed", pass_count + fail_count, pass_count,
			fail_count);
		if (fail_count == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// File: logic/castling_check.sv
module castling_check (
	input chess_board_pkg::board_t board,
	input logic castle_king_ok,
	input logic castle_queen_ok,
	output move_pkg::move_t king_move,
	output move_pkg::move_t queen_move,
	output logic king_valid,
	output logic queen_valid
);
	import chess_board_pkg::*;
	import move_pkg::*;

	localparam square_t sq_c1 = 6'o20;
	localparam square_t sq_e1 = 6'o40;
	localparam square_t sq_g1 = 6'o60;

	piece_t home [8]; // white's back rank, a1 to h1
	logic king_home;

	always_comb begin
		for (int f = 0; f < 8; f++) begin
			home[f] = piece_at(board, file_t'(f), 3'd0);
		end
	end

	assign king_home = home[4] == {WHITE, KING};

	// check and attacked squares are not tested here
	assign king_valid = castle_king_ok && king_home
		&& is_empty(home[5]) && is_empty(home[6])
		&& home[7] == {WHITE, ROOK};

	assign queen_valid = castle_queen_ok && king_home
		&& is_empty(home[1]) && is_empty(home[2]) && is_empty(home[3])
		&& home[0] == {WHITE, ROOK};

	assign king_move = king_valid ? make_move(CASTLE_FLAGS, sq_e1, sq_g1) : INVALID_MOVE;
	assign queen_move = queen_valid ? make_move(CASTLE_FLAGS, sq_e1, sq_c1) : INVALID_MOVE;

endmodule

// File: logic/chess_board_pkg.sv
package chess_board_pkg;

	// one square holds {color, kind}
	typedef logic [3:0] piece_t;
	typedef logic [2:0] kind_t;

	typedef logic [2:0] file_t;
	typedef logic [2:0] rank_t;

	// {file, rank}, file a and rank 1 are zero
	typedef logic [5:0] square_t;

	// file a in the low 32 bits, rank r at bits 4r+3:4r within a file
	typedef logic [255:0] board_t;

	typedef logic [7:0] file_mask_t; // bit 0 is file a

	localparam logic WHITE = 1'b0;
	localparam logic BLACK = 1'b1;

	localparam kind_t EMPTY = 3'd0;
	localparam kind_t PAWN = 3'd1;
	localparam kind_t KNIGHT = 3'd2;
	localparam kind_t BISHOP = 3'd3;
	localparam kind_t ROOK = 3'd4;
	localparam kind_t QUEEN = 3'd5;
	localparam kind_t KING = 3'd6;

	function automatic square_t make_square(file_t f, rank_t r);
		return {f, r};
	endfunction

	function automatic piece_t piece_at(board_t b, file_t f, rank_t r);
		return b[{f, r, 2'b00} +: 4];
	endfunction

	// an empty square may carry either color bit
	function automatic logic is_empty(piece_t p);
		return p[2:0] == EMPTY;
	endfunction

endpackage

// File: logic/en_passant_finder.sv
module en_passant_finder (
	input chess_board_pkg::board_t board,
	input chess_board_pkg::file_mask_t en_passant_files,
	output move_pkg::move_t moves [move_pkg::EN_PASSANT_COUNT],
	output logic [move_pkg::EN_PASSANT_COUNT-1:0] valid
);
	import chess_board_pkg::*;
	import move_pkg::*;

	localparam rank_t rank_5 = 3'd4;
	localparam rank_t rank_6 = 3'd5;

	// file f gets two slots, 2f for the pawn on f-1 and 2f+1 for the pawn on f+1
	for (genvar f = 0; f < 8; f++) begin : g_file
		for (genvar s = 0; s < 2; s++) begin : g_side
			localparam int src = f - 1 + 2 * s;
			localparam int idx = 2 * f + s;

			if (src >= 0 && src < 8) begin : g_on_board
				logic hit;
				square_t from_sq;
				square_t to_sq;

				assign from_sq = make_square(file_t'(src), rank_5);
				assign to_sq = make_square(file_t'(f), rank_6);

				// black pawns beside the target file do not count
				assign hit = en_passant_files[f]
					&& piece_at(board, file_t'(src), rank_5) == {WHITE, PAWN};

				assign valid[idx] = hit;
				assign moves[idx] = hit ? make_move(EN_PASSANT_FLAGS, from_sq, to_sq)
					: INVALID_MOVE;
			end else begin : g_off_board
				assign valid[idx] = 1'b0; // no neighbour past the a or h file
				assign moves[idx] = INVALID_MOVE;
			end
		end
	end

endmodule

// File: logic/move_fifo.sv
module move_fifo #(
	parameter int depth = 32
) (
	input logic clk,
	input logic reset,
	input logic wr_en,
	input move_pkg::move_t wr_move,
	input logic rden,
	output move_pkg::move_t move_out,
	output logic empty
);
	import move_pkg::*;

	localparam int ptr_bits = $clog2(depth);
	localparam int count_bits = $clog2(depth + 1);

	move_t mem [depth];

	logic [ptr_bits-1:0] wr_ptr;
	logic [ptr_bits-1:0] rd_ptr;
	logic [count_bits-1:0] count;
	logic push;
	logic pop;

	assign pop = rden && !empty; // rden on an empty queue is dropped
	assign push = wr_en && (count < count_bits'(depth));

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= wr_move;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == ptr_bits'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == ptr_bits'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// head of queue shows without a read request
	assign move_out = mem[rd_ptr];
	assign empty = count == '0;

endmodule

// File: logic/move_pkg.sv
package move_pkg;

	// from the top: invalid, promote, pawn move, pawn two squares,
	// en passant, castle, capture
	typedef logic [6:0] move_flags_t;

	// {flags, from square, to square}
	typedef logic [18:0] move_t;

	localparam move_flags_t CASTLE_FLAGS = 7'b000_0010;
	localparam move_flags_t EN_PASSANT_FLAGS = 7'b001_0101;
	localparam move_t INVALID_MOVE = {7'b100_0000, 6'o00, 6'o00};

	// slot 0 kingside, slot 1 queenside, then two slots per file
	localparam int SLOT_KING_CASTLE = 0;
	localparam int SLOT_QUEEN_CASTLE = 1;
	localparam int EN_PASSANT_BASE = 2;
	localparam int EN_PASSANT_COUNT = 16;
	localparam int CANDIDATE_COUNT = EN_PASSANT_BASE + EN_PASSANT_COUNT;

	typedef logic [CANDIDATE_COUNT-1:0] candidate_mask_t;

	function automatic move_t make_move(
		move_flags_t flags,
		chess_board_pkg::square_t from_sq,
		chess_board_pkg::square_t to_sq
	);
		return {flags, from_sq, to_sq};
	endfunction

endpackage

// File: logic/move_serializer.sv
module move_serializer (
	input logic clk,
	input logic reset,
	input move_pkg::move_t castle_moves [2],
	input logic [1:0] castle_valid,
	input move_pkg::move_t en_passant_moves [move_pkg::EN_PASSANT_COUNT],
	input logic [move_pkg::EN_PASSANT_COUNT-1:0] en_passant_valid,
	output logic wr_en,
	output move_pkg::move_t wr_move,
	output logic done
);
	import move_pkg::*;

	localparam int slot_bits = $clog2(CANDIDATE_COUNT);

	typedef enum logic [1:0] {
		capture,
		emit,
		finished
	} state_t;

	state_t state;

	move_t candidates [CANDIDATE_COUNT];
	move_t slots [CANDIDATE_COUNT];
	candidate_mask_t candidate_valid;
	candidate_mask_t pending;
	logic [slot_bits-1:0] pick;

	always_comb begin
		candidates[SLOT_KING_CASTLE] = castle_moves[0];
		candidates[SLOT_QUEEN_CASTLE] = castle_moves[1];
		for (int i = 0; i < EN_PASSANT_COUNT; i++) begin
			candidates[EN_PASSANT_BASE + i] = en_passant_moves[i];
		end
	end

	assign candidate_valid = {en_passant_valid, castle_valid};

	// lowest pending slot wins
	always_comb begin
		pick = '0;
		for (int i = CANDIDATE_COUNT - 1; i >= 0; i--) begin
			if (pending[i]) begin
				pick = slot_bits'(i);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= capture;
			pending <= '0;
		end else begin
			case (state)
				capture: begin
					pending <= candidate_valid; // board sampled once
					state <= emit;
				end
				emit: begin
					if (pending == '0) begin
						state <= finished;
					end else begin
						pending[pick] <= 1'b0;
					end
				end
				default: begin
					state <= finished; // holds until the next reset
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == capture) begin
			slots <= candidates;
		end
	end

	assign wr_en = (state == emit) && (pending != '0);
	assign wr_move = slots[pick];
	assign done = state == finished;

endmodule

// File: logic/special_move_gen.sv
module special_move_gen #(
	parameter int fifo_depth = 32
) (
	input logic clk,
	input logic reset,
	input chess_board_pkg::board_t board,
	input logic castle_king_ok,
	input logic castle_queen_ok,
	input chess_board_pkg::file_mask_t en_passant_files,
	input logic rden,
	output move_pkg::move_t move_out,
	output logic fifo_empty,
	output logic done
);
	import move_pkg::*;

	move_t king_move;
	move_t queen_move;
	logic king_valid;
	logic queen_valid;
	move_t castle_moves [2];

	move_t en_passant_moves [EN_PASSANT_COUNT];
	logic [EN_PASSANT_COUNT-1:0] en_passant_valid;

	logic wr_en;
	move_t wr_move;

	castling_check i_castling_check (
		.board(board),
		.castle_king_ok(castle_king_ok),
		.castle_queen_ok(castle_queen_ok),
		.king_move(king_move),
		.queen_move(queen_move),
		.king_valid(king_valid),
		.queen_valid(queen_valid)
	);

	assign castle_moves[0] = king_move; // kingside first
	assign castle_moves[1] = queen_move;

	en_passant_finder i_en_passant_finder (
		.board(board),
		.en_passant_files(en_passant_files),
		.moves(en_passant_moves),
		.valid(en_passant_valid)
	);

	move_serializer i_move_serializer (
		.clk(clk),
		.reset(reset),
		.castle_moves(castle_moves),
		.castle_valid({queen_valid, king_valid}),
		.en_passant_moves(en_passant_moves),
		.en_passant_valid(en_passant_valid),
		.wr_en(wr_en),
		.wr_move(wr_move),
		.done(done)
	);

	move_fifo #(
		.depth(fifo_depth)
	) i_move_fifo (
		.clk(clk),
		.reset(reset),
		.wr_en(wr_en),
		.wr_move(wr_move),
		.rden(rden),
		.move_out(move_out),
		.empty(fifo_empty)
	);

endmodule

// File: verilog.f
logic/chess_board_pkg.sv
logic/move_pkg.sv
logic/castling_check.sv
logic/en_passant_finder.sv
logic/move_serializer.sv
logic/move_fifo.sv
logic/special_move_gen.sv
bench/clock_gen.sv
bench/special_move_gen_tb.sv
